//--- files.f
verilog/mem_bridge_pkg.sv
verilog/burst_sop_tracker.sv
verilog/ready_enable_skid.sv
verilog/avalon_to_axi_bank.sv
verilog/bank_steering.sv
verilog/mem_bridge_top.sv
verification/axi_bank_model.sv
verification/tb_mem_bridge.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the memory bridge testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f files.f --top-module tb_mem_bridge -o tb_mem_bridge
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output="$(./obj_dir/tb_mem_bridge)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1

//--- verification/tb_mem_bridge.sv
// Memory bridge testbench with clock, reset, Avalon stimulus, readback checks and summary
`timescale 1ns/1ps
`default_nettype none

module tb_mem_bridge
    import mem_bridge_pkg::*;
();

    localparam int TIMEOUT = 200;
    localparam int DEPTH   = 16;

    logic                      clk;
    logic                      reset;
    avl_cmd_t                  cmd;
    logic [BANK_SEL_WIDTH-1:0] bank_sel;
    logic                      waitrequest;
    avl_rsp_t                  rsp;
    logic [NUM_BANKS-1:0]      ar_valid;
    logic [NUM_BANKS-1:0]      ar_ready;
    logic [NUM_BANKS-1:0]      aw_valid;
    logic [NUM_BANKS-1:0]      aw_ready;
    logic [NUM_BANKS-1:0]      w_valid;
    logic [NUM_BANKS-1:0]      w_ready;
    axi_addr_t                 ar [NUM_BANKS];
    axi_addr_t                 aw [NUM_BANKS];
    axi_w_t                    w [NUM_BANKS];
    axi_r_t                    r [NUM_BANKS];
    logic [NUM_BANKS-1:0]      stall_en;
    logic [NUM_BANKS-1:0]      idle;
    int                        aw_count [NUM_BANKS];
    int                        model_errs [NUM_BANKS];

    // Expected contents of every bank follow the writes issued here
    logic [DATA_WIDTH-1:0]     shadow [NUM_BANKS][DEPTH];
    logic [DATA_WIDTH-1:0]     beat_data [4];
    logic [BYTE_EN_WIDTH-1:0]  beat_be [4];

    int errs;
    int checks;
    int wait_cycles;
    int timing_errs = 0;
    int timing_beats = 0;
    int stray_valids = 0;
    logic                      prev_rvalid;
    logic [DATA_WIDTH-1:0]     prev_rdata;

    mem_bridge_top dut_i (
        .clk         (clk),
        .reset       (reset),
        .cmd         (cmd),
        .bank_sel    (bank_sel),
        .waitrequest (waitrequest),
        .rsp         (rsp),
        .ar_valid    (ar_valid),
        .ar          (ar),
        .ar_ready    (ar_ready),
        .aw_valid    (aw_valid),
        .aw          (aw),
        .aw_ready    (aw_ready),
        .w_valid     (w_valid),
        .w           (w),
        .w_ready     (w_ready),
        .r           (r)
    );

    for (genvar b = 0; b < NUM_BANKS; b++)
    begin : g_model
        axi_bank_model #(.BANK_ID(b)) model_i (
            .clk       (clk),
            .reset     (reset),
            .stall_en  (stall_en[b]),
            .ar_valid  (ar_valid[b]),
            .ar        (ar[b]),
            .ar_ready  (ar_ready[b]),
            .aw_valid  (aw_valid[b]),
            .aw        (aw[b]),
            .aw_ready  (aw_ready[b]),
            .w_valid   (w_valid[b]),
            .w         (w[b]),
            .w_ready   (w_ready[b]),
            .r         (r[b]),
            .idle      (idle[b]),
            .aw_count  (aw_count[b]),
            .err_count (model_errs[b])
        );
    end

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ==================================================
    // Response timing and bank isolation monitor
    // ==================================================

    always @(posedge clk)
    begin
        if (reset)
            prev_rvalid <= 1'b0;
        else
        begin
            // Read data of the selected bank must reappear on rsp one cycle later
            assert (rsp.readdatavalid == prev_rvalid)
            else
            begin
                timing_errs++;
                $display("ERR %0t rsp.readdatavalid expected %0d actual %0d", $time,
                         prev_rvalid, rsp.readdatavalid);
            end
            if (prev_rvalid)
            begin
                timing_beats++;
                assert (rsp.readdata == prev_rdata)
                else
                begin
                    timing_errs++;
                    $display("ERR %0t rsp.readdata expected %h actual %h", $time,
                             prev_rdata, rsp.readdata);
                end
            end
            for (int b = 0; b < NUM_BANKS; b++)
            begin
                if (b != int'(bank_sel) && (ar_valid[b] || aw_valid[b] || w_valid[b]))
                    stray_valids++;
            end
            prev_rvalid <= r[bank_sel].rvalid;
        end
        prev_rdata <= r[bank_sel].data;
    end

    // ==================================================
    // Helpers
    // ==================================================

    function automatic int total_errors();
        int sum;
        sum = errs + timing_errs;
        for (int b = 0; b < NUM_BANKS; b++)
            sum += model_errs[b];
        return sum;
    endfunction

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        checks++;
        assert (act === exp)
        else
        begin
            errs++;
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_idle_outputs();
        check_value("ar_valid", 64'(0), 64'(ar_valid));
        check_value("aw_valid", 64'(0), 64'(aw_valid));
        check_value("w_valid", 64'(0), 64'(w_valid));
        check_value("rsp.readdatavalid", 64'(0), 64'(rsp.readdatavalid));
        check_value("waitrequest", 64'(0), 64'(waitrequest));
    endtask

    // Called right after a clock edge and returns on the edge that accepts the beat
    task automatic drive_beat(input avl_cmd_t c);
        int t;
        cmd <= c;
        for (t = 0; t < TIMEOUT; t++)
        begin
            @(posedge clk);
            if (!waitrequest)
                break;
            wait_cycles++;
        end
        if (t == TIMEOUT)
        begin
            errs++;
            $display("Timeout at %0t: waitrequest stayed high for %0d cycles", $time, TIMEOUT);
        end
    endtask

    task automatic wait_bank_idle(input int bank);
        int t;
        for (t = 0; t < TIMEOUT; t++)
        begin
            @(posedge clk);
            if (idle[bank])
                break;
        end
        if (t == TIMEOUT)
        begin
            errs++;
            $display("Timeout at %0t: bank %0d never finished its writes", $time, bank);
        end
    endtask

    task automatic write_burst(input int bank, input int addr, input int n);
        avl_cmd_t c;
        bank_sel <= BANK_SEL_WIDTH'(bank);
        for (int i = 0; i < n; i++)
        begin
            c            = '0;
            c.write      = 1'b1;
            c.address    = LINE_ADDR_WIDTH'(addr);
            c.burstcount = BURST_CNT_WIDTH'(n);
            c.writedata  = beat_data[i];
            c.byteenable = beat_be[i];
            drive_beat(c);
            // Only enabled byte lanes change the stored line
            for (int k = 0; k < BYTE_EN_WIDTH; k++)
            begin
                if (beat_be[i][k])
                    shadow[bank][addr + i][8*k +: 8] = beat_data[i][8*k +: 8];
            end
        end
        cmd <= '0;
        wait_bank_idle(bank);
    endtask

    task automatic read_burst(input int bank, input int addr, input int n);
        avl_cmd_t c;
        int got;
        int t;
        c            = '0;
        c.read       = 1'b1;
        c.address    = LINE_ADDR_WIDTH'(addr);
        c.burstcount = BURST_CNT_WIDTH'(n);
        bank_sel <= BANK_SEL_WIDTH'(bank);
        drive_beat(c);
        cmd <= '0;
        got = 0;
        for (t = 0; t < TIMEOUT && got < n; t++)
        begin
            @(posedge clk);
            if (rsp.readdatavalid)
            begin
                check_value("rsp.readdata", shadow[bank][addr + got], rsp.readdata);
                got++;
            end
        end
        if (got < n)
        begin
            errs++;
            $display("Timeout at %0t: only %0d of %0d read beats returned", $time, got, n);
        end
        // Nothing may follow the last beat of the burst
        for (t = 0; t < 8; t++)
        begin
            @(posedge clk);
            if (rsp.readdatavalid)
            begin
                errs++;
                $display("Extra readdatavalid at %0t after a %0d beat burst", $time, n);
            end
        end
    endtask

    task automatic fill_beats(input int n, input logic full_bytes);
        for (int i = 0; i < n; i++)
        begin
            beat_data[i] = {$urandom, $urandom};
            beat_be[i]   = full_bytes ? 8'hff : 8'($urandom);
        end
    endtask

    task automatic report_test(input int num, input string name, input int start_errs);
        $display("Test %0d %s: %0d errors", num, name, total_errors() - start_errs);
    endtask

    // ==================================================
    // Test sequence
    // ==================================================

    initial
    begin
        int start_errs;
        int aw_before;
        int stray_before;
        int beats_before;
        int bank;
        int n;
        int addr;

        void'($urandom(19));
        reset       = 1'b1;
        cmd         = '0;
        bank_sel    = '0;
        stall_en    = '0;
        errs        = 0;
        checks      = 0;
        wait_cycles = 0;
        for (int b = 0; b < NUM_BANKS; b++)
        begin
            for (int i = 0; i < DEPTH; i++)
                shadow[b][i] = {32'(b) ^ 32'h5a5a_0000, 32'(i) * 32'h0101_0101 ^ 32'hc3c3_c3c3};
        end

        // Outputs are checked from the second reset edge on
        start_errs = total_errors();
        for (int i = 0; i < 4; i++)
        begin
            @(posedge clk);
            if (i > 0)
                check_idle_outputs();
        end
        reset <= 1'b0;
        for (int i = 0; i < 2; i++)
        begin
            @(posedge clk);
            check_idle_outputs();
        end
        report_test(1, "reset state", start_errs);

        start_errs = total_errors();
        fill_beats(1, 1'b1);
        write_burst(0, 5, 1);
        read_burst(0, 5, 1);
        report_test(2, "single beat write and readback", start_errs);

        start_errs = total_errors();
        aw_before  = aw_count[0];
        fill_beats(4, 1'b1);
        write_burst(0, 8, 4);
        check_value("aw_count[0] delta", 64'(1), 64'(aw_count[0] - aw_before));
        read_burst(0, 8, 4);
        report_test(3, "four beat burst", start_errs);

        // Same line in both banks with complementary data
        start_errs   = total_errors();
        stray_before = stray_valids;
        fill_beats(1, 1'b1);
        write_burst(0, 3, 1);
        beat_data[0] = ~beat_data[0];
        write_burst(1, 3, 1);
        read_burst(0, 3, 1);
        read_burst(1, 3, 1);
        check_value("stray_valids delta", 64'(0), 64'(stray_valids - stray_before));
        report_test(4, "bank isolation", start_errs);

        start_errs  = total_errors();
        wait_cycles = 0;
        stall_en   <= '1;
        for (int i = 0; i < 20; i++)
        begin
            bank = int'($urandom % NUM_BANKS);
            n    = 1 + int'($urandom % 4);
            addr = int'($urandom % (DEPTH - n + 1));
            fill_beats(n, 1'b0);
            write_burst(bank, addr, n);
            read_burst(bank, addr, n);
        end
        stall_en <= '0;
        // The random stalls must have held at least one command on waitrequest
        assert (wait_cycles > 0)
        else
        begin
            errs++;
            $display("Back-pressure never raised waitrequest during the random bursts");
        end
        report_test(5, "back-pressure", start_errs);

        start_errs   = total_errors();
        beats_before = timing_beats;
        fill_beats(3, 1'b1);
        write_burst(1, 10, 3);
        read_burst(1, 10, 3);
        check_value("timing_beats delta", 64'(3), 64'(timing_beats - beats_before));
        report_test(6, "response timing", start_errs);

        $display("Tests run: 6, checks: %0d, errors: %0d", checks, total_errors());
        if (total_errors() == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/axi_bank_model.sv
// Behavioral AXI memory bank with random ready stalls, burst read return and protocol checks
`timescale 1ns/1ps
`default_nettype none

module axi_bank_model
    import mem_bridge_pkg::*;
#(
    parameter int BANK_ID = 0
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      stall_en,
    input  logic      ar_valid,
    input  axi_addr_t ar,
    output logic      ar_ready,
    input  logic      aw_valid,
    input  axi_addr_t aw,
    output logic      aw_ready,
    input  logic      w_valid,
    input  axi_w_t    w,
    output logic      w_ready,
    output axi_r_t    r,
    output logic      idle,
    output int        aw_count,
    output int        err_count
);

    localparam int DEPTH = 16;

    // Small line memory indexed by the low bits of the line address
    logic [DATA_WIDTH-1:0]    mem [DEPTH];

    // Accepted beats waiting to be paired with their write address
    axi_addr_t                aw_q [$];
    axi_addr_t                ar_q [$];
    logic [DATA_WIDTH-1:0]    wd_q [$];
    logic [BYTE_EN_WIDTH-1:0] ws_q [$];
    logic                     wl_q [$];

    int wr_beat;
    int wr_line;
    int rd_line;
    int rd_left;
    int rd_wait;
    int pending;
    int aw_errs = 0;
    int ar_errs = 0;
    int w_errs = 0;

    // Each line starts with a word built from the bank and the whole line index
    function automatic logic [DATA_WIDTH-1:0] fill_word(input int line);
        return {32'(BANK_ID) ^ 32'h5a5a_0000, 32'(line) * 32'h0101_0101 ^ 32'hc3c3_c3c3};
    endfunction

    assign idle      = (pending == 0) && !aw_valid && !w_valid;
    assign err_count = aw_errs + ar_errs + w_errs;

    // ==================================================
    // Address channel checks
    // ==================================================

    assert property (@(posedge clk) disable iff (reset)
        aw_valid |-> (aw.addr[ADDR_BYTE_IDX_WIDTH-1:0] == '0) && (aw.len < 8'd4) &&
                     (aw.size == 3'(ADDR_BYTE_IDX_WIDTH)))
    else
    begin
        aw_errs++;
        $display(
            "ERR %0t aw bank %0d expected aligned len<4 size %0d, actual addr %h len %0d size %0d",
            $time, BANK_ID, ADDR_BYTE_IDX_WIDTH, aw.addr, aw.len, aw.size);
    end

    assert property (@(posedge clk) disable iff (reset)
        ar_valid |-> (ar.addr[ADDR_BYTE_IDX_WIDTH-1:0] == '0) && (ar.len < 8'd4) &&
                     (ar.size == 3'(ADDR_BYTE_IDX_WIDTH)))
    else
    begin
        ar_errs++;
        $display(
            "ERR %0t ar bank %0d expected aligned len<4 size %0d, actual addr %h len %0d size %0d",
            $time, BANK_ID, ADDR_BYTE_IDX_WIDTH, ar.addr, ar.len, ar.size);
    end

    // ==================================================
    // Channel handling
    // ==================================================

    always @(posedge clk)
    begin
        if (reset)
        begin
            ar_ready <= 1'b0;
            aw_ready <= 1'b0;
            w_ready  <= 1'b0;
            r        <= '0;
            aw_count <= 0;
            pending  <= 0;
            aw_q.delete();
            ar_q.delete();
            wd_q.delete();
            ws_q.delete();
            wl_q.delete();
            wr_beat = 0;
            rd_left = 0;
            rd_wait = 0;
            for (int i = 0; i < DEPTH; i++)
                mem[i] = fill_word(i);
        end
        else
        begin
            // With stalls enabled each ready drops on about one cycle in four
            ar_ready <= !stall_en || ($urandom % 4 != 0);
            aw_ready <= !stall_en || ($urandom % 4 != 0);
            w_ready  <= !stall_en || ($urandom % 4 != 0);

            if (ar_valid && ar_ready)
                ar_q.push_back(ar);
            if (aw_valid && aw_ready)
            begin
                aw_q.push_back(aw);
                aw_count <= aw_count + 1;
            end
            if (w_valid && w_ready)
            begin
                wd_q.push_back(w.data);
                ws_q.push_back(w.strb);
                wl_q.push_back(w.last);
            end

            // A write beat lands once its burst address is known
            if (aw_q.size() > 0 && wd_q.size() > 0)
            begin
                wr_line = (int'(aw_q[0].addr >> ADDR_BYTE_IDX_WIDTH) + wr_beat) % DEPTH;
                for (int k = 0; k < BYTE_EN_WIDTH; k++)
                begin
                    if (ws_q[0][k])
                        mem[wr_line][8*k +: 8] = wd_q[0][8*k +: 8];
                end
                assert (wl_q[0] == (wr_beat == int'(aw_q[0].len)))
                else
                begin
                    w_errs++;
                    $display("ERR %0t w.last bank %0d beat %0d expected %0d actual %0d", $time,
                             BANK_ID, wr_beat, wr_beat == int'(aw_q[0].len), wl_q[0]);
                end
                void'(wd_q.pop_front());
                void'(ws_q.pop_front());
                void'(wl_q.pop_front());
                if (wr_beat == int'(aw_q[0].len))
                begin
                    void'(aw_q.pop_front());
                    wr_beat = 0;
                end
                else
                    wr_beat++;
            end

            // Read bursts start after a short random delay and then stream one beat per cycle
            if (rd_left == 0 && ar_q.size() > 0)
            begin
                rd_line = int'(ar_q[0].addr >> ADDR_BYTE_IDX_WIDTH);
                rd_left = int'(ar_q[0].len) + 1;
                rd_wait = stall_en ? int'($urandom % 4) : 0;
                void'(ar_q.pop_front());
            end
            if (rd_left > 0 && rd_wait == 0)
            begin
                r.rvalid <= 1'b1;
                r.data   <= mem[rd_line % DEPTH];
                rd_line++;
                rd_left--;
            end
            else
            begin
                if (rd_wait > 0)
                    rd_wait--;
                r <= '0;
            end

            pending <= aw_q.size() + wd_q.size();
        end
    end

endmodule

`default_nettype wire

//--- verilog/mem_bridge_top.sv
// Memory bridge top joining bank steering and per-bank AXI translation
`timescale 1ns/1ps
`default_nettype none

module mem_bridge_top
    import mem_bridge_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,

    // Avalon host side
    input  avl_cmd_t                  cmd,
    input  logic [BANK_SEL_WIDTH-1:0] bank_sel,
    output logic                      waitrequest,
    output avl_rsp_t                  rsp,

    // AXI channels, one set per bank
    output logic [NUM_BANKS-1:0]      ar_valid,
    output axi_addr_t                 ar [NUM_BANKS],
    input  logic [NUM_BANKS-1:0]      ar_ready,
    output logic [NUM_BANKS-1:0]      aw_valid,
    output axi_addr_t                 aw [NUM_BANKS],
    input  logic [NUM_BANKS-1:0]      aw_ready,
    output logic [NUM_BANKS-1:0]      w_valid,
    output axi_w_t                    w [NUM_BANKS],
    input  logic [NUM_BANKS-1:0]      w_ready,
    input  axi_r_t                    r [NUM_BANKS]
);

    // Per-bank handshake between steering and translation
    logic [NUM_BANKS-1:0] bank_stall;
    logic [NUM_BANKS-1:0] bank_cmd_en;

    bank_steering steering_i (
        .clk         (clk),
        .reset       (reset),
        .cmd         (cmd),
        .bank_sel    (bank_sel),
        .bank_stall  (bank_stall),
        .bank_cmd_en (bank_cmd_en),
        .waitrequest (waitrequest),
        .bank_r      (r),
        .rsp         (rsp)
    );

    // Every bank sees the same command, only its enable differs
    for (genvar b = 0; b < NUM_BANKS; b++)
    begin : g_bank
        avalon_to_axi_bank bank_i (
            .clk      (clk),
            .reset    (reset),
            .cmd      (cmd),
            .cmd_en   (bank_cmd_en[b]),
            .stall    (bank_stall[b]),
            .ar_valid (ar_valid[b]),
            .aw_valid (aw_valid[b]),
            .w_valid  (w_valid[b]),
            .ar       (ar[b]),
            .aw       (aw[b]),
            .w        (w[b]),
            .ar_ready (ar_ready[b]),
            .aw_ready (aw_ready[b]),
            .w_ready  (w_ready[b])
        );
    end

endmodule

`default_nettype wire

//--- verilog/bank_steering.sv
// Bank select decode, waitrequest mux and registered read response
`timescale 1ns/1ps
`default_nettype none

module bank_steering
    import mem_bridge_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  avl_cmd_t                  cmd,
    input  logic [BANK_SEL_WIDTH-1:0] bank_sel,
    input  logic [NUM_BANKS-1:0]      bank_stall,
    output logic [NUM_BANKS-1:0]      bank_cmd_en,
    output logic                      waitrequest,
    input  axi_r_t                    bank_r [NUM_BANKS],
    output avl_rsp_t                  rsp
);

    // Registered copy of the selected bank's read beat
    logic                  rsp_valid_q;
    logic [DATA_WIDTH-1:0] rsp_data_q;

    // Only the selected bank can hold the host off
    assign waitrequest = bank_stall[bank_sel];

    always_comb
    begin
        // A beat is accepted by the selected bank when it has room
        for (int b = 0; b < NUM_BANKS; b++)
        begin
            bank_cmd_en[b] = (bank_sel == BANK_SEL_WIDTH'(b)) &&
                             (cmd.read || cmd.write) &&
                             !bank_stall[b];
        end
    end

    // ==================================================
    // Read return one cycle behind the bank
    // ==================================================

    always_ff @(posedge clk)
    begin
        if (reset)
            rsp_valid_q <= 1'b0;
        else
            rsp_valid_q <= bank_r[bank_sel].rvalid;
    end

    always_ff @(posedge clk)
    begin
        rsp_data_q <= bank_r[bank_sel].data;
    end

    assign rsp.readdatavalid = rsp_valid_q;
    assign rsp.readdata      = rsp_data_q;

endmodule

`default_nettype wire

//--- verilog/avalon_to_axi_bank.sv
// Per-bank Avalon to AXI command translation with ar, aw and w skid buffers
`timescale 1ns/1ps
`default_nettype none

module avalon_to_axi_bank
    import mem_bridge_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  avl_cmd_t  cmd,
    input  logic      cmd_en,
    output logic      stall,
    output logic      ar_valid,
    output logic      aw_valid,
    output logic      w_valid,
    output axi_addr_t ar,
    output axi_addr_t aw,
    output axi_w_t    w,
    input  logic      ar_ready,
    input  logic      aw_ready,
    input  logic      w_ready
);

    // ==================================================
    // Skid buffer inputs
    // ==================================================

    logic      ar_in_valid;
    logic      aw_in_valid;
    logic      w_in_valid;
    logic      ar_in_ready;
    logic      aw_in_ready;
    logic      w_in_ready;
    axi_addr_t addr_in;
    axi_w_t    w_in;

    // Burst position of the current write beat
    logic      write_beat;
    logic      is_sop;
    logic      is_eop;

    // Steering already folded in the strobe and the stall, so cmd_en means accepted
    assign write_beat = cmd_en && cmd.write;

    burst_sop_tracker sop_tracker_i (
        .clk        (clk),
        .reset      (reset),
        .beat_valid (write_beat),
        .burstcount (cmd.burstcount),
        .sop        (is_sop),
        .eop        (is_eop)
    );

    // Any full skid buffer holds the whole command, even channels it does not use
    assign stall = !ar_in_ready || !aw_in_ready || !w_in_ready;

    always_comb
    begin
        // Line address padded with zero byte index bits gives the AXI byte address
        addr_in      = '0;
        addr_in.addr = {cmd.address, ADDR_BYTE_IDX_WIDTH'(0)};
        // AXI counts beats from zero, Avalon from one
        addr_in.len  = AXI_LEN_WIDTH'(cmd.burstcount) - AXI_LEN_WIDTH'(1);
        addr_in.size = AXI_SIZE_WIDTH'(ADDR_BYTE_IDX_WIDTH);

        w_in      = '0;
        w_in.data = cmd.writedata;
        w_in.strb = cmd.byteenable;
        w_in.last = is_eop;

        // The write address goes out once per burst, on its first beat
        ar_in_valid = cmd_en && cmd.read;
        aw_in_valid = write_beat && is_sop;
        w_in_valid  = write_beat;
    end

    // ==================================================
    // One skid buffer per AXI command channel
    // ==================================================

    ready_enable_skid #(.N_DATA_BITS($bits(axi_addr_t))) ar_skid_i (
        .clk             (clk),
        .reset           (reset),
        .enable_from_src (ar_in_valid),
        .data_from_src   (addr_in),
        .ready_to_src    (ar_in_ready),
        .enable_to_dst   (ar_valid),
        .data_to_dst     (ar),
        .ready_from_dst  (ar_ready)
    );

    ready_enable_skid #(.N_DATA_BITS($bits(axi_addr_t))) aw_skid_i (
        .clk             (clk),
        .reset           (reset),
        .enable_from_src (aw_in_valid),
        .data_from_src   (addr_in),
        .ready_to_src    (aw_in_ready),
        .enable_to_dst   (aw_valid),
        .data_to_dst     (aw),
        .ready_from_dst  (aw_ready)
    );

    ready_enable_skid #(.N_DATA_BITS($bits(axi_w_t))) w_skid_i (
        .clk             (clk),
        .reset           (reset),
        .enable_from_src (w_in_valid),
        .data_from_src   (w_in),
        .ready_to_src    (w_in_ready),
        .enable_to_dst   (w_valid),
        .data_to_dst     (w),
        .ready_from_dst  (w_ready)
    );

endmodule

`default_nettype wire

//--- verilog/ready_enable_skid.sv
// Two-entry ready/valid skid buffer with registered output and registered ready
`timescale 1ns/1ps
`default_nettype none

module ready_enable_skid #(
    parameter int N_DATA_BITS = 32
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   enable_from_src,
    input  logic [N_DATA_BITS-1:0] data_from_src,
    output logic                   ready_to_src,
    output logic                   enable_to_dst,
    output logic [N_DATA_BITS-1:0] data_to_dst,
    input  logic                   ready_from_dst
);

    // The main entry drives the output and the skid entry catches overflow
    logic                   main_valid;
    logic [N_DATA_BITS-1:0] main_data;
    logic                   skid_valid;
    logic [N_DATA_BITS-1:0] skid_data;

    logic accept_in;
    logic main_free;

    // Ready comes straight from a flop, so there is always room for one beat
    assign ready_to_src  = !skid_valid;
    assign enable_to_dst = main_valid;
    assign data_to_dst   = main_data;

    assign accept_in = enable_from_src && ready_to_src;

    // The main entry can load when empty or when its beat leaves this cycle
    assign main_free = !main_valid || ready_from_dst;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
        end
        else if (main_free)
        begin
            // A parked beat goes first to keep order
            main_valid <= skid_valid || accept_in;
            skid_valid <= 1'b0;
        end
        else if (accept_in)
        begin
            skid_valid <= 1'b1;
        end
    end

    // Payload follows the same selection as the valid bits
    always_ff @(posedge clk)
    begin
        if (main_free)
            main_data <= skid_valid ? skid_data : data_from_src;
        else if (accept_in)
            skid_data <= data_from_src;
    end

endmodule

`default_nettype wire

//--- verilog/burst_sop_tracker.sv
// Write burst beat counter producing start and end of packet flags
`timescale 1ns/1ps
`default_nettype none

module burst_sop_tracker
    import mem_bridge_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       beat_valid,
    input  logic [BURST_CNT_WIDTH-1:0] burstcount,
    output logic                       sop,
    output logic                       eop
);

    // Beats still owed by the burst in progress drop to zero between bursts
    logic [BURST_CNT_WIDTH-1:0] beats_left;

    // A new burst starts whenever nothing is owed
    assign sop = (beats_left == '0);

    // On the first beat the burstcount decides and later beats look at the count
    assign eop = sop ? (burstcount == BURST_CNT_WIDTH'(1)) :
                       (beats_left == BURST_CNT_WIDTH'(1));

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            beats_left <= '0;
        end
        else if (beat_valid)
        begin
            // The first beat loads the remainder of the burst
            if (sop)
                beats_left <= burstcount - BURST_CNT_WIDTH'(1);
            else
                beats_left <= beats_left - BURST_CNT_WIDTH'(1);
        end
    end

endmodule

`default_nettype wire

//--- verilog/mem_bridge_pkg.sv
// Bridge widths, bank count and the Avalon command, AXI channel and response structs
`default_nettype none

package mem_bridge_pkg;

    // ==================================================
    // Geometry
    // ==================================================

    // Two local memory banks with only one active at a time
    localparam int NUM_BANKS           = 2;
    localparam int BANK_SEL_WIDTH      = $clog2(NUM_BANKS);

    // One 64 bit beat per line, so eight byte lanes
    localparam int DATA_WIDTH          = 64;
    localparam int BYTE_EN_WIDTH       = DATA_WIDTH / 8;
    localparam int ADDR_BYTE_IDX_WIDTH = $clog2(BYTE_EN_WIDTH);

    // Avalon addresses count lines and AXI addresses count bytes
    localparam int LINE_ADDR_WIDTH     = 26;
    localparam int AXI_ADDR_WIDTH      = LINE_ADDR_WIDTH + ADDR_BYTE_IDX_WIDTH;

    // Avalon bursts run from 1 to 4 beats
    localparam int BURST_CNT_WIDTH     = 3;

    // Standard AXI len and size field widths
    localparam int AXI_LEN_WIDTH       = 8;
    localparam int AXI_SIZE_WIDTH      = 3;

    // ==================================================
    // Avalon side
    // ==================================================

    // The controller holds this command word steady while waitrequest is high
    typedef struct packed {
        logic                       read;
        logic                       write;
        logic [LINE_ADDR_WIDTH-1:0] address;
        logic [BURST_CNT_WIDTH-1:0] burstcount;
        logic [DATA_WIDTH-1:0]      writedata;
        logic [BYTE_EN_WIDTH-1:0]   byteenable;
    } avl_cmd_t;

    // Read return towards the host
    typedef struct packed {
        logic                  readdatavalid;
        logic [DATA_WIDTH-1:0] readdata;
    } avl_rsp_t;

    // ==================================================
    // AXI side
    // ==================================================

    // Shared by the read address and write address channels
    typedef struct packed {
        logic [AXI_ADDR_WIDTH-1:0] addr;
        logic [AXI_LEN_WIDTH-1:0]  len;
        logic [AXI_SIZE_WIDTH-1:0] size;
    } axi_addr_t;

    // Write data beat
    typedef struct packed {
        logic [DATA_WIDTH-1:0]    data;
        logic [BYTE_EN_WIDTH-1:0] strb;
        logic                     last;
    } axi_w_t;

    // Read data beat that the bridge always accepts
    typedef struct packed {
        logic                  rvalid;
        logic [DATA_WIDTH-1:0] data;
    } axi_r_t;

endpackage

`default_nettype wire
